/* verilog/dmi_pkg.sv */
// DMI transport definitions (op codes, response codes, field widths); imported by DMI-facing blocks
`default_nettype none

package dmi_pkg;

    // field widths of one DMI request / response
    localparam int DMI_ADDR_W = 7;
    localparam int DMI_DATA_W = 32;

    // request op, driven by the DTM
    typedef enum logic [1:0] {
        NOP   = 2'd0,  // no access, still answered
        READ  = 2'd1,
        WRITE = 2'd2,
        RSVD  = 2'd3   // reserved, answered with FAILED
    } dmi_op_e;

    // response code returned with every request
    typedef enum logic [1:0] {
        SUCCESS = 2'd0,
        FAILED  = 2'd2  // 1 and 3 never produced here
    } dmi_resp_e;

endpackage : dmi_pkg

`default_nettype wire

/* verilog/dm_pkg.sv */
// debug register map, 0.13 register layouts and hart count; imported by every debug module block
`default_nettype none

package dm_pkg;

    // number of harts behind this debug module
    localparam int NR_HARTS  = 4;
    // index width, at least one bit
    localparam int HART_BITS = (NR_HARTS == 1) ? 1 : $clog2(NR_HARTS);

    localparam logic [3:0] DM_VERSION = 4'd2;  // spec 0.13

    // response queue geometry
    localparam int RESP_DEPTH = 2;
    localparam int RESP_PTR_W = (RESP_DEPTH > 1) ? $clog2(RESP_DEPTH) : 1;
    localparam int RESP_CNT_W = $clog2(RESP_DEPTH + 1);  // holds 0..RESP_DEPTH

    // debug register addresses
    localparam logic [6:0] ADDR_DATA0     = 7'h04;
    localparam logic [6:0] ADDR_DMCONTROL = 7'h10;
    localparam logic [6:0] ADDR_DMSTATUS  = 7'h11;
    localparam logic [6:0] ADDR_HALTSUM0  = 7'h40;

    // dmcontrol, msb first
    typedef struct packed {
        logic       haltreq;       // 31
        logic       resumereq;     // 30
        logic       hartreset;     // 29
        logic       ackhavereset;  // 28
        logic       zero1;         // 27
        logic       hasel;         // 26
        logic [9:0] hartsello;     // 25:16
        logic [9:0] hartselhi;     // 15:6, unused here
        logic [3:0] zero0;         // 5:2, resethaltreq bits not implemented
        logic       ndmreset;      // 1
        logic       dmactive;      // 0
    } dmcontrol_t;

    // dmstatus, msb first
    typedef struct packed {
        logic [8:0] zero1;             // 31:23
        logic       impebreak;         // 22
        logic [1:0] zero0;             // 21:20
        logic       allhavereset;
        logic       anyhavereset;
        logic       allresumeack;
        logic       anyresumeack;
        logic       allnonexistent;
        logic       anynonexistent;
        logic       allunavail;
        logic       anyunavail;
        logic       allrunning;
        logic       anyrunning;
        logic       allhalted;
        logic       anyhalted;         // 8
        logic       authenticated;     // 7
        logic       authbusy;
        logic       hasresethaltreq;
        logic       devtreeaddrvalid;  // 4
        logic [3:0] version;           // 3:0
    } dmstatus_t;

    // one register word, layout picked by address
    typedef union packed {
        dmcontrol_t  ctrl;
        dmstatus_t   stat;
        logic [31:0] raw;
    } dm_word_u;

endpackage : dm_pkg

`default_nettype wire

/* verilog/dm_hart_if.sv */
// selected hart index and its status summary, between the register block and the hart status block
`timescale 1ns/1ps
`default_nettype none

interface dm_hart_if import dm_pkg::*; ();

    logic [HART_BITS-1:0] hartsel;  // from dmcontrol.hartsello

    // status of the selected hart
    logic        anyhalted;
    logic        allhalted;
    logic        anyrunning;
    logic        allrunning;
    logic        anyunavail;
    logic        allunavail;
    logic [31:0] haltsum;  // halted vector, zero-extended

    // register block side
    modport csrs (
        output hartsel,
        input  anyhalted, allhalted, anyrunning, allrunning,
        input  anyunavail, allunavail, haltsum
    );

    // status reducer side
    modport status (
        input  hartsel,
        output anyhalted, allhalted, anyrunning, allrunning,
        output anyunavail, allunavail, haltsum
    );

endinterface : dm_hart_if

`default_nettype wire

/* verilog/dm_resp_fifo.sv */
// response queue for DMI answers, circular buffer of {resp, data} popped by the DTM handshake
`timescale 1ns/1ps
`default_nettype none

module dm_resp_fifo
    import dmi_pkg::*;
    import dm_pkg::*;
(
    input  logic                  clk_i,
    input  logic                  rst_ni,
    input  logic                  push_i,
    input  dmi_resp_e             resp_i,
    input  logic [DMI_DATA_W-1:0] data_i,
    input  logic                  pop_i,   // resp ready from the DTM
    output logic                  full_o,
    output logic                  valid_o,
    output dmi_resp_e             resp_o,
    output logic [DMI_DATA_W-1:0] data_o
);

    dmi_resp_e             resp_mem [RESP_DEPTH];
    logic [DMI_DATA_W-1:0] data_mem [RESP_DEPTH];

    logic [RESP_PTR_W-1:0] wr_ptr_q;
    logic [RESP_PTR_W-1:0] rd_ptr_q;
    logic [RESP_CNT_W-1:0] count_q;
    logic                  do_push;
    logic                  do_pop;

    assign full_o  = (count_q == RESP_CNT_W'(RESP_DEPTH));
    assign valid_o = (count_q != '0);  // not empty

    assign do_push = push_i & ~full_o;
    assign do_pop  = pop_i & valid_o;  // pop on empty ignored

    // head entry, no bypass
    assign resp_o = resp_mem[rd_ptr_q];
    assign data_o = data_mem[rd_ptr_q];

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (do_push) begin
                // wrap at the last slot
                wr_ptr_q <= (wr_ptr_q == RESP_PTR_W'(RESP_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (do_pop) begin
                rd_ptr_q <= (rd_ptr_q == RESP_PTR_W'(RESP_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: ;  // both or neither, level unchanged
            endcase
        end
    end

    // storage
    always_ff @(posedge clk_i) begin
        if (do_push) begin
            resp_mem[wr_ptr_q] <= resp_i;
            data_mem[wr_ptr_q] <= data_i;
        end
    end

endmodule : dm_resp_fifo

`default_nettype wire

/* verilog/dm_hart_status.sv */
// reduces per-hart status inputs to the selected hart's any/all flags and the haltsum0 word
`timescale 1ns/1ps
`default_nettype none

module dm_hart_status
    import dm_pkg::*;
(
    input  logic [NR_HARTS-1:0] halted_i,
    input  logic [NR_HARTS-1:0] running_i,
    input  logic [NR_HARTS-1:0] unavailable_i,  // e.g. powered down
    dm_hart_if.status           hart
);

    logic sel_halted;
    logic sel_running;
    logic sel_unavail;

    // pick the selected hart's bits
    always_comb begin
        sel_halted  = 1'b0;
        sel_running = 1'b0;
        sel_unavail = 1'b0;
        // out-of-range index reads as zero
        if (int'(hart.hartsel) < NR_HARTS) begin
            sel_halted  = halted_i[hart.hartsel];
            sel_running = running_i[hart.hartsel];
            sel_unavail = unavailable_i[hart.hartsel];
        end
    end

    // single hart selected, so any == all
    assign hart.anyhalted  = sel_halted;
    assign hart.allhalted  = sel_halted;
    assign hart.anyrunning = sel_running;
    assign hart.allrunning = sel_running;
    assign hart.anyunavail = sel_unavail;
    assign hart.allunavail = sel_unavail;

    // haltsum0, one bit per hart, independent of hartsel
    always_comb begin
        hart.haltsum                 = '0;
        hart.haltsum[NR_HARTS-1:0]   = halted_i;
    end

endmodule : dm_hart_status

`default_nettype wire

/* verilog/dm_csrs.sv */
// DMI request decode and debug register file, drives halt/resume requests and the response push
`timescale 1ns/1ps
`default_nettype none

module dm_csrs
    import dmi_pkg::*;
    import dm_pkg::*;
(
    input  logic                  clk_i,
    input  logic                  rst_ni,
    input  logic                  req_valid_i,
    input  logic [DMI_ADDR_W-1:0] req_addr_i,
    input  logic [1:0]            req_op_i,
    input  logic [DMI_DATA_W-1:0] req_data_i,
    input  logic                  fifo_full_i,  // no room for a response
    output logic                  push_o,
    output dmi_resp_e             push_resp_o,
    output logic [DMI_DATA_W-1:0] push_data_o,
    dm_hart_if.csrs               hart,
    output logic [NR_HARTS-1:0]   haltreq_o,
    output logic [NR_HARTS-1:0]   resumereq_o,
    output logic                  ndmreset_o
);

    dmi_op_e               op;
    logic                  accept;
    dm_word_u              rd_word;  // read view of the addressed register
    dm_word_u              wr_word;  // write data as a register layout
    dmcontrol_t            dmcontrol_d, dmcontrol_q;
    logic [DMI_DATA_W-1:0] data0_d, data0_q;

    assign op      = dmi_op_e'(req_op_i);
    assign accept  = req_valid_i & ~fifo_full_i;  // one response per accepted request
    assign push_o  = accept;
    assign wr_word.raw = req_data_i;

    assign hart.hartsel = dmcontrol_q.hartsello[HART_BITS-1:0];

    // register read, old values only
    always_comb begin
        rd_word = '0;  // unknown address reads zero
        case (req_addr_i)
            ADDR_DATA0: rd_word.raw = data0_q;
            ADDR_DMCONTROL: begin
                rd_word.ctrl.haltreq   = dmcontrol_q.haltreq;
                rd_word.ctrl.resumereq = dmcontrol_q.resumereq;
                rd_word.ctrl.hartsello = dmcontrol_q.hartsello;
                rd_word.ctrl.ndmreset  = dmcontrol_q.ndmreset;
                rd_word.ctrl.dmactive  = dmcontrol_q.dmactive;
            end
            ADDR_DMSTATUS: begin
                rd_word.stat.version       = DM_VERSION;
                rd_word.stat.authenticated = 1'b1;  // no authentication
                rd_word.stat.allunavail    = hart.allunavail;
                rd_word.stat.anyunavail    = hart.anyunavail;
                rd_word.stat.allrunning    = hart.allrunning;
                rd_word.stat.anyrunning    = hart.anyrunning;
                rd_word.stat.allhalted     = hart.allhalted;
                rd_word.stat.anyhalted     = hart.anyhalted;
            end
            ADDR_HALTSUM0: rd_word.raw = hart.haltsum;
            default: ;
        endcase
    end

    // response word
    always_comb begin
        push_resp_o = SUCCESS;
        push_data_o = '0;  // nop and write answer zero
        case (op)
            READ:    push_data_o = rd_word.raw;
            RSVD:    push_resp_o = FAILED;
            default: ;
        endcase
    end

    // register write
    always_comb begin
        dmcontrol_d = dmcontrol_q;
        data0_d     = data0_q;
        if (accept && op == WRITE) begin
            case (req_addr_i)
                ADDR_DATA0: data0_d = req_data_i;
                ADDR_DMCONTROL: begin
                    dmcontrol_d          = '0;  // hartselhi and unused fields stay zero
                    dmcontrol_d.dmactive = wr_word.ctrl.dmactive;
                    // inactive module keeps nothing else
                    if (wr_word.ctrl.dmactive) begin
                        dmcontrol_d.haltreq   = wr_word.ctrl.haltreq;
                        dmcontrol_d.resumereq = wr_word.ctrl.resumereq;
                        dmcontrol_d.ndmreset  = wr_word.ctrl.ndmreset;
                        // only the bits that index a real hart
                        dmcontrol_d.hartsello[HART_BITS-1:0] =
                            wr_word.ctrl.hartsello[HART_BITS-1:0];
                    end
                end
                default: ;  // writes elsewhere dropped
            endcase
        end
    end

    // per-hart requests, one-hot on the selection
    always_comb begin
        haltreq_o   = '0;
        resumereq_o = '0;
        if (int'(hart.hartsel) < NR_HARTS) begin
            haltreq_o[hart.hartsel]   = dmcontrol_q.haltreq;
            resumereq_o[hart.hartsel] = dmcontrol_q.resumereq;
        end
    end

    assign ndmreset_o = dmcontrol_q.ndmreset;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            dmcontrol_q <= '0;
            data0_q     <= '0;
        end else begin
            dmcontrol_q <= dmcontrol_d;
            data0_q     <= data0_d;
        end
    end

endmodule : dm_csrs

`default_nettype wire

/* verilog/dm_top.sv */
// debug module front end top, DMI request/response and hart status/control on plain ports
`timescale 1ns/1ps
`default_nettype none

module dm_top
    import dmi_pkg::*;
    import dm_pkg::*;
(
    input  logic                  clk_i,
    input  logic                  rst_ni,
    // DMI request
    input  logic                  dmi_req_valid_i,
    output logic                  dmi_req_ready_o,
    input  logic [DMI_ADDR_W-1:0] dmi_req_addr_i,
    input  logic [1:0]            dmi_req_op_i,  // nop, read, write, reserved
    input  logic [DMI_DATA_W-1:0] dmi_req_data_i,
    // DMI response
    output logic                  dmi_resp_valid_o,
    input  logic                  dmi_resp_ready_i,
    output logic [1:0]            dmi_resp_resp_o,
    output logic [DMI_DATA_W-1:0] dmi_resp_data_o,
    // hart status
    input  logic [NR_HARTS-1:0]   halted_i,
    input  logic [NR_HARTS-1:0]   running_i,
    input  logic [NR_HARTS-1:0]   unavailable_i,
    // hart control
    output logic [NR_HARTS-1:0]   haltreq_o,
    output logic [NR_HARTS-1:0]   resumereq_o,
    output logic                  ndmreset_o
);

    logic                  fifo_full;
    logic                  push;
    dmi_resp_e             push_resp;
    logic [DMI_DATA_W-1:0] push_data;

    dm_hart_if hart_if ();

    assign dmi_req_ready_o = ~fifo_full;  // accept while a slot is free

    dm_csrs u_csrs (
        .clk_i       ( clk_i           ),
        .rst_ni      ( rst_ni          ),
        .req_valid_i ( dmi_req_valid_i ),
        .req_addr_i  ( dmi_req_addr_i  ),
        .req_op_i    ( dmi_req_op_i    ),
        .req_data_i  ( dmi_req_data_i  ),
        .fifo_full_i ( fifo_full       ),
        .push_o      ( push            ),
        .push_resp_o ( push_resp       ),
        .push_data_o ( push_data       ),
        .hart        ( hart_if.csrs    ),
        .haltreq_o   ( haltreq_o       ),
        .resumereq_o ( resumereq_o     ),
        .ndmreset_o  ( ndmreset_o      )
    );

    dm_hart_status u_hart_status (
        .halted_i      ( halted_i       ),
        .running_i     ( running_i      ),
        .unavailable_i ( unavailable_i  ),
        .hart          ( hart_if.status )
    );

    // pop straight from resp ready, ignored when empty
    dm_resp_fifo u_resp_fifo (
        .clk_i   ( clk_i            ),
        .rst_ni  ( rst_ni           ),
        .push_i  ( push             ),
        .resp_i  ( push_resp        ),
        .data_i  ( push_data        ),
        .pop_i   ( dmi_resp_ready_i ),
        .full_o  ( fifo_full        ),
        .valid_o ( dmi_resp_valid_o ),
        .resp_o  ( dmi_resp_resp_o  ),
        .data_o  ( dmi_resp_data_o  )
    );

endmodule : dm_top

`default_nettype wire

/* verif/tb_dm_top.sv */
// testbench for dm_top that replays verif/dm_stim.txt under random response back-pressure
`timescale 1ns/1ps
`default_nettype none

module tb_dm_top
    import dmi_pkg::*;
    import dm_pkg::*;
();

    logic                  clk_i;
    logic                  rst_ni;
    logic                  dmi_req_valid_i;
    logic                  dmi_req_ready_o;
    logic [DMI_ADDR_W-1:0] dmi_req_addr_i;
    logic [1:0]            dmi_req_op_i;
    logic [DMI_DATA_W-1:0] dmi_req_data_i;
    logic                  dmi_resp_valid_o;
    logic                  dmi_resp_ready_i;
    logic [1:0]            dmi_resp_resp_o;
    logic [DMI_DATA_W-1:0] dmi_resp_data_o;
    logic [NR_HARTS-1:0]   halted_i, running_i, unavailable_i;
    logic [NR_HARTS-1:0]   haltreq_o, resumereq_o;
    logic                  ndmreset_o;

    // stimulus table with one entry per file line
    int          st_grp [64];
    logic [1:0]  st_op [64];
    logic [6:0]  st_addr [64];
    logic [31:0] st_data [64];
    logic [3:0]  st_halted [64], st_running [64], st_unavail [64];
    logic [1:0]  st_resp [64];
    logic [31:0] st_rdata [64];
    logic [3:0]  st_haltreq [64], st_resumereq [64];
    logic        st_ndmreset [64];

    logic [33:0] exp_q [$];  // {resp, data} in request order
    logic [33:0] entry;
    logic [1:0]  cur_resp;   // expectations of the request on the bus
    logic [31:0] cur_data;
    logic [3:0]  cur_haltreq, cur_resumereq, out_haltreq, out_resumereq;
    logic        cur_ndmreset, out_ndmreset;
    logic        out_check_pend;
    int          errors, grp_err_base, nr_lines, nr_req, nr_resp, cycles, cycle_limit, fd, n, i;
    string       line;

    dm_top uut (
        .clk_i, .rst_ni,
        .dmi_req_valid_i, .dmi_req_ready_o, .dmi_req_addr_i, .dmi_req_op_i, .dmi_req_data_i,
        .dmi_resp_valid_o, .dmi_resp_ready_i, .dmi_resp_resp_o, .dmi_resp_data_o,
        .halted_i, .running_i, .unavailable_i,
        .haltreq_o, .resumereq_o, .ndmreset_o
    );

    task automatic check_value(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %0t: %s, got %0h expected %0h", $time, what, got, exp);
        end
    endtask

    task automatic load_stimulus();
        fd = $fopen("verif/dm_stim.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("could not open the stimulus file verif/dm_stim.txt");
        end else begin
            while (!$feof(fd) && nr_lines < 64) begin
                n = $fgets(line, fd);
                // skip blanks and column notes
                if (n > 1 && line.substr(0, 0) != "#") begin
                    n = $sscanf(line, "%d %h %h %h %h %h %h %h %h %h %h %h",
                        st_grp[nr_lines], st_op[nr_lines], st_addr[nr_lines],
                        st_data[nr_lines], st_halted[nr_lines], st_running[nr_lines],
                        st_unavail[nr_lines], st_resp[nr_lines], st_rdata[nr_lines],
                        st_haltreq[nr_lines], st_resumereq[nr_lines], st_ndmreset[nr_lines]);
                    if (n == 12) begin
                        nr_lines++;
                    end else begin
                        errors++;
                        $display("malformed stimulus line: %s", line);
                    end
                end
            end
            $fclose(fd);
        end
        cycle_limit = 40 * nr_lines + 100;  // generous per-request budget
    endtask

    initial begin : clock_gen
        clk_i = 1'b0;
        forever #20 clk_i = ~clk_i;
    end

    initial begin : watchdog
        while (cycles <= cycle_limit) begin
            @(posedge clk_i);
            cycles++;
        end
        $display("timeout: run hung waiting for responses after %0d cycles", cycles);
        $display(">>> FAIL");
        $finish;
    end

    // resp ready low about a third of the time
    initial begin : resp_ready_gen
        dmi_resp_ready_i = 1'b0;
        void'($urandom(3));  // same back-pressure pattern every run
        forever begin
            @(posedge clk_i);
            #2;
            dmi_resp_ready_i = ($urandom % 3) != 0;
        end
    end

    // sample on the falling edge away from input changes
    always @(negedge clk_i) begin
        if (rst_ni) begin
            check_value(32'(dmi_req_ready_o), 32'(exp_q.size() < 2), "request ready");
            check_value(32'(dmi_resp_valid_o), 32'(exp_q.size() > 0), "response valid");
            if (out_check_pend) begin  // one cycle after acceptance
                check_value(32'(haltreq_o), 32'(out_haltreq), "haltreq_o");
                check_value(32'(resumereq_o), 32'(out_resumereq), "resumereq_o");
                check_value(32'(ndmreset_o), 32'(out_ndmreset), "ndmreset_o");
                out_check_pend = 1'b0;
            end
            if (dmi_resp_valid_o && dmi_resp_ready_i && exp_q.size() > 0) begin
                entry = exp_q.pop_front();
                check_value(32'(dmi_resp_resp_o), 32'(entry[33:32]), "response code");
                check_value(dmi_resp_data_o, entry[31:0], "response data");
                nr_resp++;
            end
            if (dmi_req_valid_i && dmi_req_ready_o) begin
                exp_q.push_back({cur_resp, cur_data});
                out_haltreq    = cur_haltreq;
                out_resumereq  = cur_resumereq;
                out_ndmreset   = cur_ndmreset;
                out_check_pend = 1'b1;
                nr_req++;
            end
        end
    end

    initial begin : driver
        $timeformat(-9, 0, " ns", 0);
        errors = 0;
        cycle_limit = 100;
        rst_ni = 1'b0;
        dmi_req_valid_i = 1'b0;
        dmi_req_addr_i = '0;
        dmi_req_op_i = '0;
        dmi_req_data_i = '0;
        halted_i = '0;
        running_i = '0;
        unavailable_i = '0;
        out_check_pend = 1'b0;
        load_stimulus();
        repeat (8) @(posedge clk_i);
        #2 rst_ni = 1'b1;
        for (i = 0; i < nr_lines; i++) begin
            @(posedge clk_i);
            #2;
            dmi_req_valid_i = 1'b1;
            dmi_req_op_i    = st_op[i];
            dmi_req_addr_i  = st_addr[i];
            dmi_req_data_i  = st_data[i];
            halted_i        = st_halted[i];
            running_i       = st_running[i];
            unavailable_i   = st_unavail[i];
            cur_resp        = st_resp[i];
            cur_data        = st_rdata[i];
            cur_haltreq     = st_haltreq[i];
            cur_resumereq   = st_resumereq[i];
            cur_ndmreset    = st_ndmreset[i];
            @(negedge clk_i);
            while (!dmi_req_ready_o) @(negedge clk_i);  // held until accepted
            if (i == nr_lines - 1 || st_grp[i + 1] != st_grp[i]) begin
                @(posedge clk_i);
                #2 dmi_req_valid_i = 1'b0;
                while (exp_q.size() != 0 || out_check_pend) @(posedge clk_i);  // drain group
                $display("group %0d done, %0d errors", st_grp[i], errors - grp_err_base);
                grp_err_base = errors;
            end
        end
        check_value(nr_resp, nr_lines, "response count");
        $display("summary: %0d lines, %0d requests, %0d responses, %0d errors",
                 nr_lines, nr_req, nr_resp, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule : tb_dm_top

`default_nettype wire

/* verif/dm_stim.txt */
# grp op addr data halted running unavail | exp: resp data haltreq resumereq ndmreset
# op 0 nop 1 read 2 write 3 reserved, all fields but grp in hex
1 1 10 00000000 1 e 0 0 00000000 0 0 0
1 1 11 00000000 1 e 0 0 00000382 0 0 0
1 1 11 00000000 0 1 0 0 00000c82 0 0 0
1 1 7f 00000000 0 1 0 0 00000000 0 0 0
2 2 04 deadbeef 0 1 0 0 00000000 0 0 0
2 1 04 00000000 0 1 0 0 deadbeef 0 0 0
2 0 04 12345678 0 1 0 0 00000000 0 0 0
2 3 04 12345678 0 1 0 2 00000000 0 0 0
3 2 10 80020002 0 1 0 0 00000000 0 0 0
3 1 10 00000000 0 1 0 0 00000000 0 0 0
3 2 10 03ffffc1 0 1 0 0 00000000 0 0 0
3 1 10 00000000 0 1 0 0 00030001 0 0 0
3 1 11 00000000 0 7 8 0 00003082 0 0 0
4 2 10 80010001 2 d 0 0 00000000 2 0 0
4 1 11 00000000 2 d 0 0 00000382 2 0 0
4 2 10 40020003 0 0 4 0 00000000 0 4 1
4 1 11 00000000 0 0 4 0 00003082 0 4 1
4 2 10 c0030001 0 8 0 0 00000000 8 8 0
4 1 10 00000000 0 8 0 0 c0030001 8 8 0
5 1 40 00000000 5 0 0 0 00000005 8 8 0
5 1 40 00000000 a 0 0 0 0000000a 8 8 0
5 1 40 00000000 f 0 0 0 0000000f 8 8 0
6 2 04 11111111 0 0 0 0 00000000 8 8 0
6 1 04 00000000 0 0 0 0 11111111 8 8 0
6 2 10 00000000 0 0 0 0 00000000 0 0 0
6 1 10 00000000 0 0 0 0 00000000 0 0 0

/* compile.f */
verilog/dmi_pkg.sv
verilog/dm_pkg.sv
verilog/dm_hart_if.sv
verilog/dm_resp_fifo.sv
verilog/dm_hart_status.sv
verilog/dm_csrs.sv
verilog/dm_top.sv
verif/tb_dm_top.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps \
    --top-module tb_dm_top -f compile.f \
    -Mdir obj_dir -o sim_tb_dm_top

./obj_dir/sim_tb_dm_top > sim.log 2>&1
cat sim.log

if grep -q ">>> FAIL" sim.log; then
    echo "simulation reported a failure"
    exit 1
fi
echo "simulation finished without failures"
